/* tb/carsim_testdata.txt */
# columns: command, then hex arguments. W addr data, R addr expect, I open_us,
# E event_idx, S sim_run, C cycles, G window_cycles (count ignition cycles)
R 0 0
R 1 0
R 2 0
R 3 0
R 4 0
R 5 0
R 6 0
W 0 1234
R 0 1234
W 0 200
S 1
E 1
W 6 1
R 6 0
W 4 5
E 0
R 4 0
W 6 0
R 6 0
W 5 5
E 3
R 5 0
W 6 3
R 6 0
I 7
R 3 7
R 2 1
I 3
R 3 3
R 2 2
I c
R 3 c
R 2 3
E 2
W 6 2
W 2 0
R 2 0
R 6 0
W 7 a
E 5
W 6 5
E 7
W 7 8000
R 6 0
S 0
W 4 a
C 64
R 4 a
R 6 0
S 1
E 0
R 4 0
W 6 0
W 0 14
W 1 0
G 1400
R 0 14

/* all.f */
source/carsim_pkg.sv
source/tick_gen.sv
source/down_timer.sv
source/ignition_gen.sv
source/injector_monitor.sv
source/event_controller.sv
source/carsim_top.sv
tb/carsim_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps --top-module carsim_tb \
    -f all.f -o carsim_sim &&
./obj_dir/carsim_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb/carsim_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module carsim_tb;

    import carsim_pkg::*;

    localparam int cycles_per_us = 4;
    localparam int event_timeout = 4000;
    localparam int coil_timeout  = 400;

    logic                  sysclk;
    logic                  sim_reset;
    logic                  sim_run;
    logic                  injector_open;
    bus_req_t              bus;
    logic [data_width-1:0] read_data;
    logic                  ign_coil_lo;
    logic                  event_pending;

    logic [15:0] lfsr_state;
    int          check_count;
    int          coil_falls;
    logic        coil_prev;

    carsim_top #(.cycles_per_us(cycles_per_us), .us_per_jiffy(2), .us_per_ms(10)) dut (
        .sysclk(sysclk), .sim_reset(sim_reset), .sim_run(sim_run), .bus(bus),
        .injector_open(injector_open), .read_data(read_data), .ign_coil_lo(ign_coil_lo),
        .event_pending(event_pending));

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;
    end

    // galois form, taps for a maximal 16-bit sequence.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    // inputs change 1 ns after the edge.
    task automatic step();
        @(posedge sysclk);
        #1;
    endtask

    task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting: %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [15:0] data);
        bus.load = 1'b1;
        bus.addr = reg_addr_e'(addr);
        bus.data = data;
        step();
        bus.load = 1'b0;
    endtask

    // read_data is combinational, so it is sampled mid-cycle.
    task automatic read_check(input logic [2:0] addr, input logic [15:0] expected);
        bus.load = 1'b0;
        bus.addr = reg_addr_e'(addr);
        #2;
        check_value(read_data, expected, $sformatf("read of register %0d", addr));
        if (addr == reg_event) begin
            check_value({15'd0, event_pending}, {15'd0, expected[15]}, "event_pending level");
        end
        step();
    endtask

    task automatic wait_event(input logic [15:0] idx);
        int waited;
        waited = 0;
        while (!event_pending) begin
            if (waited >= event_timeout) fail_timeout("event_pending never rose");
            step();
            waited++;
        end
        read_check(reg_event, 16'h8000 | idx);
    endtask

    // gap of 2 to 9 cycles, one lfsr step per bit.
    task automatic draw_gap(output int cycles);
        int i;
        cycles = 2;
        for (i = 0; i < 3; i++) begin
            cycles = cycles + (int'(lfsr_state[0]) << i);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic puff(input int open_us);
        int gap;
        injector_open = 1'b1;
        repeat (open_us * cycles_per_us) step();
        injector_open = 1'b0;
        draw_gap(gap);
        repeat (gap) step();
    endtask

    task automatic coil_step();
        step();
        if (coil_prev && !ign_coil_lo) coil_falls++;
        coil_prev = ign_coil_lo;
    endtask

    // every ignition cycle ends with one falling edge of the coil output.
    task automatic ignition_window(input int window);
        int waited;
        coil_falls = 0;
        coil_prev = ign_coil_lo;
        repeat (window) coil_step();
        waited = 0;
        while (ign_coil_lo) begin
            if (waited >= coil_timeout) fail_timeout("ign_coil_lo to fall after the window");
            coil_step();
            waited++;
        end
        check_value(16'(coil_falls > 0), 16'd1, "ignition cycles seen in window");
        read_check(reg_ign_cycle_cnt, 16'(coil_falls));
    endtask

    initial begin
        int          fd;
        int          code;
        logic [7:0]  cmd;
        logic [15:0] arg_a;
        logic [15:0] arg_b;
        sim_reset = 1'b1;
        sim_run = 1'b0;
        injector_open = 1'b0;
        bus = '0;
        lfsr_state = 16'd26147;
        check_count = 0;
        repeat (3) @(posedge sysclk);
        #1;
        sim_reset = 1'b0;
        step();
        fd = $fopen("tb/carsim_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/carsim_testdata.txt");
            $display("TESTBENCH FAILED");
            $fatal(1, "missing stimulus");
        end
        while ($fscanf(fd, " %c", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgetc(fd);
                while (code != 10 && code != -1) code = $fgetc(fd);
            end else if (cmd == "W" || cmd == "R") begin
                code = $fscanf(fd, " %h %h", arg_a, arg_b);
                if (cmd == "W") write_reg(arg_a[2:0], arg_b);
                else read_check(arg_a[2:0], arg_b);
            end else begin
                code = $fscanf(fd, " %h", arg_a);
                case (cmd)
                    "I": puff(int'(arg_a));
                    "E": wait_event(arg_a);
                    "S": begin
                        sim_run = arg_a[0];
                        step();
                    end
                    "C": repeat (int'(arg_a)) step();
                    "G": ignition_window(int'(arg_a));
                    default: begin
                        $display("unknown command %c in the stimulus file", cmd);
                        $display("TESTBENCH FAILED");
                        $fatal(1, "bad stimulus");
                    end
                endcase
            end
        end
        $fclose(fd);
        if (check_count > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("the stimulus file held no checks");
            $display("TESTBENCH FAILED");
            $fatal(1, "empty stimulus");
        end
    end

endmodule

`default_nettype wire

/* source/carsim_top.sv */
`timescale 1ns/10ps
`default_nettype none

module carsim_top #(
    parameter int cycles_per_us = 50,
    parameter int us_per_jiffy  = 20,
    parameter int us_per_ms     = 1000
) (
    input  logic                             sysclk,
    input  logic                             sim_reset,
    input  logic                             sim_run,
    input  carsim_pkg::bus_req_t             bus,
    input  logic                             injector_open,
    output logic [carsim_pkg::data_width-1:0] read_data,
    output logic                             ign_coil_lo,
    output logic                             event_pending
);

    import carsim_pkg::*;

    logic us_tick, jiffy_tick, ms_tick;
    logic ustimer_expired, mstimer_expired, ign_end, puff_end;
    logic ign_period_load, ign_cycle_clear, puff_cnt_clear;
    logic ustimer_load, mstimer_load, event_ack, soft_event_load, soft_reset;
    logic [3:0]            soft_pulse;
    logic [num_events-1:0] event_vec;
    logic [data_width-1:0] ign_period, ign_cycle_cnt, puff_cnt, puff_len;
    logic [data_width-1:0] ustimer_count, mstimer_count, event_status;

    // write decode into one-cycle load strobes.
    assign ign_period_load = bus.load && (bus.addr == reg_ign_period);
    assign ign_cycle_clear = bus.load && (bus.addr == reg_ign_cycle_cnt);
    assign puff_cnt_clear  = bus.load && (bus.addr == reg_puff_cnt);
    assign ustimer_load    = bus.load && (bus.addr == reg_ustimer);
    assign mstimer_load    = bus.load && (bus.addr == reg_mstimer);
    assign event_ack       = bus.load && (bus.addr == reg_event);
    assign soft_event_load = bus.load && (bus.addr == reg_soft_event);

    // the reset bit takes the whole write, no soft events are raised with it.
    assign soft_reset = soft_event_load && bus.data[event_reset_bit];
    assign soft_pulse = (soft_event_load && !bus.data[event_reset_bit]) ? bus.data[3:0] : 4'b0;

    always_comb begin
        case (bus.addr)
            reg_ign_period:    read_data = ign_period;
            reg_ign_cycle_cnt: read_data = ign_cycle_cnt;
            reg_puff_cnt:      read_data = puff_cnt;
            reg_puff_len:      read_data = puff_len;
            reg_ustimer:       read_data = ustimer_count;
            reg_mstimer:       read_data = mstimer_count;
            reg_event:         read_data = event_status;
            default:           read_data = '0;
        endcase
    end

    always_comb begin
        event_vec                = '0;
        event_vec[ev_ustimer]    = ustimer_expired;
        event_vec[ev_ign_end]    = ign_end;
        event_vec[ev_puff_end]   = puff_end;
        event_vec[ev_mstimer]    = mstimer_expired;
        event_vec[ev_soft0 +: 4] = soft_pulse;
    end

    // the ungated tick is only for blocks that must run while paused; none here yet.
    tick_gen #(.cycles_per_us(cycles_per_us), .us_per_jiffy(us_per_jiffy),
               .us_per_ms(us_per_ms)) ticks (
        .sysclk(sysclk), .sim_reset(sim_reset), .sim_run(sim_run), .us_tick(us_tick),
        .us_tick_ungated(), .jiffy_tick(jiffy_tick), .ms_tick(ms_tick));

    down_timer ustimer (
        .sysclk(sysclk), .sim_reset(sim_reset), .tick(us_tick), .load(ustimer_load),
        .data(bus.data), .count(ustimer_count), .expired(ustimer_expired));

    down_timer mstimer (
        .sysclk(sysclk), .sim_reset(sim_reset), .tick(ms_tick), .load(mstimer_load),
        .data(bus.data), .count(mstimer_count), .expired(mstimer_expired));

    ignition_gen ignition (
        .sysclk(sysclk), .sim_reset(sim_reset), .jiffy_tick(jiffy_tick),
        .period_load(ign_period_load), .cycle_clear(ign_cycle_clear), .data(bus.data),
        .period(ign_period), .cycle_cnt(ign_cycle_cnt), .coil_lo(ign_coil_lo),
        .ign_end(ign_end));

    injector_monitor injector (
        .sysclk(sysclk), .sim_reset(sim_reset), .us_tick(us_tick),
        .injector_open(injector_open), .cnt_clear(puff_cnt_clear), .puff_cnt(puff_cnt),
        .puff_len(puff_len), .puff_end(puff_end));

    event_controller #(.num_events(num_events)) events (
        .sysclk(sysclk), .sim_reset(sim_reset), .soft_reset(soft_reset), .ack(event_ack),
        .ack_idx(event_idx_e'(bus.data[2:0])), .event_pulses(event_vec),
        .status(event_status), .any_pending(event_pending));

endmodule

`default_nettype wire

/* source/event_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module event_controller #(
    parameter int num_events = carsim_pkg::num_events
) (
    input  logic                             sysclk,
    input  logic                             sim_reset,
    input  logic                             soft_reset,
    input  logic                             ack,
    input  carsim_pkg::event_idx_e           ack_idx,
    input  logic [num_events-1:0]            event_pulses,
    output logic [carsim_pkg::data_width-1:0] status,
    output logic                             any_pending
);

    import carsim_pkg::*;

    localparam int idx_w = $clog2(num_events);

    logic [num_events-1:0] pending;
    logic [num_events-1:0] ack_mask;
    logic [idx_w-1:0]      top_idx;

    assign any_pending = |pending;

    // one-hot clear for the acknowledged source.
    always_comb begin
        ack_mask = '0;
        if (ack) begin
            ack_mask[ack_idx] = 1'b1;
        end
    end

    // priority encoder, lowest index wins.
    always_comb begin
        top_idx = '0;
        for (int i = num_events - 1; i >= 0; i--) begin
            if (pending[i]) begin
                top_idx = idx_w'(i);
            end
        end
    end

    always_comb begin
        status                 = '0;
        status[data_width-1]   = any_pending;
        status[idx_w-1:0]      = top_idx;
    end

    // a new pulse beats an acknowledge of the same source.
    always_ff @(posedge sysclk) begin
        if (sim_reset || soft_reset) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~ack_mask) | event_pulses;
        end
    end

    // software may only acknowledge a source that exists.
    a_ack_in_range: assert property (@(posedge sysclk) disable iff (sim_reset)
        ack |-> (int'(ack_idx) < num_events));

endmodule

`default_nettype wire

/* source/injector_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module injector_monitor (
    input  logic                             sysclk,
    input  logic                             sim_reset,
    input  logic                             us_tick,
    input  logic                             injector_open,
    input  logic                             cnt_clear,
    output logic [carsim_pkg::data_width-1:0] puff_cnt,
    output logic [carsim_pkg::data_width-1:0] puff_len,
    output logic                             puff_end
);

    import carsim_pkg::*;

    logic                  open_q;
    logic                  puff_start;
    logic [data_width-1:0] run_len;

    assign puff_start = injector_open && !open_q;
    assign puff_end   = open_q && !injector_open;

    always_ff @(posedge sysclk) begin
        if (sim_reset) begin
            open_q <= 1'b0;
        end else begin
            open_q <= injector_open;
        end
    end

    // running length in microseconds.
    // a tick in the opening cycle already counts toward the new puff.
    always_ff @(posedge sysclk) begin
        if (sim_reset) begin
            run_len <= '0;
        end else if (puff_start) begin
            run_len <= us_tick ? data_width'(1) : '0;
        end else if (injector_open && us_tick) begin
            run_len <= run_len + 1'b1;
        end
    end

    // capture on the closing edge so software sees a stable length.
    always_ff @(posedge sysclk) begin
        if (sim_reset) begin
            puff_len <= '0;
            puff_cnt <= '0;
        end else begin
            if (puff_end) begin
                puff_len <= run_len;
            end
            if (cnt_clear) begin
                puff_cnt <= '0;
            end else if (puff_end) begin
                puff_cnt <= puff_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/ignition_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module ignition_gen (
    input  logic                             sysclk,
    input  logic                             sim_reset,
    input  logic                             jiffy_tick,
    input  logic                             period_load,
    input  logic                             cycle_clear,
    input  logic [carsim_pkg::data_width-1:0] data,
    output logic [carsim_pkg::data_width-1:0] period,
    output logic [carsim_pkg::data_width-1:0] cycle_cnt,
    output logic                             coil_lo,
    output logic                             ign_end
);

    import carsim_pkg::*;

    logic [data_width-1:0] pulse_cnt;

    // last cycle of the coil pulse; a new period starts here.
    assign ign_end = jiffy_tick && (pulse_cnt == '0);

    // the coil is driven during the final jiffies before the counter wraps.
    assign coil_lo = (pulse_cnt < data_width'(coil_low_jiffies));

    // period in jiffies, picked up at the next wrap.
    always_ff @(posedge sysclk) begin
        if (sim_reset) begin
            period <= '0;
        end else if (period_load) begin
            period <= data;
        end
    end

    always_ff @(posedge sysclk) begin
        if (sim_reset) begin
            pulse_cnt <= '0;
        end else if (jiffy_tick) begin
            pulse_cnt <= ign_end ? period : pulse_cnt - 1'b1;
        end
    end

    // completed ignition cycles, cleared by any write.
    always_ff @(posedge sysclk) begin
        if (sim_reset || cycle_clear) begin
            cycle_cnt <= '0;
        end else if (ign_end) begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/down_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module down_timer (
    input  logic                             sysclk,
    input  logic                             sim_reset,
    input  logic                             tick,
    input  logic                             load,
    input  logic [carsim_pkg::data_width-1:0] data,
    output logic [carsim_pkg::data_width-1:0] count,
    output logic                             expired
);

    import carsim_pkg::*;

    // a load in the same cycle overrides the final tick.
    assign expired = tick && !load && (count == data_width'(1));

    always_ff @(posedge sysclk) begin
        if (sim_reset) begin
            count <= '0;
        end else if (load) begin
            count <= data;
        end else if (tick && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    // once at zero the timer parks there until software reloads it.
    a_no_wrap: assert property (@(posedge sysclk) disable iff (sim_reset)
        (count == '0 && !load) |=> (count == '0));

endmodule

`default_nettype wire

/* source/tick_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tick_gen #(
    parameter int cycles_per_us = 50,
    parameter int us_per_jiffy  = 20,
    parameter int us_per_ms     = 1000
) (
    input  logic sysclk,
    input  logic sim_reset,
    input  logic sim_run,
    output logic us_tick,
    output logic us_tick_ungated,
    output logic jiffy_tick,
    output logic ms_tick
);

    localparam int pre_w   = $clog2(cycles_per_us + 1);
    localparam int jiffy_w = $clog2(us_per_jiffy + 1);
    localparam int ms_w    = $clog2(us_per_ms + 1);

    logic [pre_w-1:0]   pre_cnt;
    logic [jiffy_w-1:0] jiffy_cnt;
    logic [ms_w-1:0]    ms_cnt;

    // the prescaler keeps running while the sim is paused, so the microsecond grid never slips.
    assign us_tick_ungated = (pre_cnt == pre_w'(cycles_per_us - 1));
    assign us_tick         = us_tick_ungated && sim_run;

    // slower ticks are derived from gated microseconds only.
    assign jiffy_tick = us_tick && (jiffy_cnt == jiffy_w'(us_per_jiffy - 1));
    assign ms_tick    = us_tick && (ms_cnt == ms_w'(us_per_ms - 1));

    always_ff @(posedge sysclk) begin
        if (sim_reset || us_tick_ungated) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (sim_reset) begin
            jiffy_cnt <= '0;
            ms_cnt    <= '0;
        end else if (us_tick) begin
            jiffy_cnt <= jiffy_tick ? '0 : jiffy_cnt + 1'b1;
            ms_cnt    <= ms_tick ? '0 : ms_cnt + 1'b1;
        end
    end

    // microsecond pulses are isolated whenever the prescaler divides at all.
    a_us_tick_single: assert property (@(posedge sysclk) disable iff (sim_reset)
        (cycles_per_us > 1 && us_tick) |=> !us_tick);

endmodule

`default_nettype wire

/* source/carsim_pkg.sv */
`default_nettype none

package carsim_pkg;

    // width of every register on the bus.
    localparam int data_width = 16;

    // register map, one address per register.
    typedef enum logic [2:0] {
        reg_ign_period    = 3'd0,
        reg_ign_cycle_cnt = 3'd1,
        reg_puff_cnt      = 3'd2,
        reg_puff_len      = 3'd3,
        reg_ustimer       = 3'd4,
        reg_mstimer       = 3'd5,
        reg_event         = 3'd6,
        reg_soft_event    = 3'd7
    } reg_addr_e;

    // bus request from the processor side.
    // load is a single-cycle write strobe; reads use addr only.
    typedef struct packed {
        logic                  load;
        reg_addr_e             addr;
        logic [data_width-1:0] data;
    } bus_req_t;

    // event sources, most urgent first.
    typedef enum logic [2:0] {
        ev_ustimer  = 3'd0,
        ev_ign_end  = 3'd1,
        ev_puff_end = 3'd2,
        ev_mstimer  = 3'd3,
        ev_soft0    = 3'd4,
        ev_soft1    = 3'd5,
        ev_soft2    = 3'd6,
        ev_soft3    = 3'd7
    } event_idx_e;

    // number of event inputs to the event controller.
    localparam int num_events = 8;

    // setting this bit in a soft event write resets the event controller.
    localparam int event_reset_bit = 15;

    // the coil output is active while the ignition counter is below this.
    localparam int coil_low_jiffies = 16;

endpackage

`default_nettype wire
